/* src/mipsPkg.sv */
package mipsPkg;

	typedef logic [31:0] dataT;     // Register and memory word
	typedef logic [4:0]  regAddrT;  // Register number
	typedef logic [8:0]  memAddrT;  // Byte address, 512 bytes
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;

	// How the ALU picks its operation
	typedef enum logic [1:0] {
		AluAdd,    // Address and plain add
		AluFunct,  // R-type, from funct
		AluImm     // Immediate ops, from opcode
	} aluModeE;

	typedef enum logic [3:0] {
		Add,
		Sub,
		And,
		Or,
		Nor,
		Xor,
		Slt,
		Sltu,
		Sllv,
		Srlv,
		Srav,
		Lui
	} aluOpE;

	typedef enum logic [3:0] {
		Fetch,
		FetchWait,
		Decode,
		ExecR,
		ExecI,
		MemAddr,
		MemRead,
		MemWrite,
		WriteBack
	} stateE;

	// Opcodes
	localparam opcodeT OpRType = 6'h00;
	localparam opcodeT OpAddi  = 6'h08;
	localparam opcodeT OpAddiu = 6'h09;
	localparam opcodeT OpSlti  = 6'h0a;
	localparam opcodeT OpSltiu = 6'h0b;
	localparam opcodeT OpAndi  = 6'h0c;
	localparam opcodeT OpOri   = 6'h0d;
	localparam opcodeT OpXori  = 6'h0e;
	localparam opcodeT OpLui   = 6'h0f;
	localparam opcodeT OpLw    = 6'h23;
	localparam opcodeT OpSw    = 6'h2b;

	// R-type funct field
	localparam functT FnSllv = 6'h04;
	localparam functT FnSrlv = 6'h06;
	localparam functT FnSrav = 6'h07;
	localparam functT FnAdd  = 6'h20;
	localparam functT FnAddu = 6'h21;
	localparam functT FnSub  = 6'h22;
	localparam functT FnSubu = 6'h23;
	localparam functT FnAnd  = 6'h24;
	localparam functT FnOr   = 6'h25;
	localparam functT FnXor  = 6'h26;
	localparam functT FnNor  = 6'h27;
	localparam functT FnSlt  = 6'h2a;
	localparam functT FnSltu = 6'h2b;

	localparam memAddrT ResetPc = 9'd0;  // First fetch
	localparam memAddrT PcStep  = 9'd4;  // One word per instruction

endpackage

/* src/registerFile.sv */
module registerFile (
	input  logic             CLK,
	input  logic             reset,
	input  logic             regWrite,
	input  mipsPkg::regAddrT rdAddrA,
	input  mipsPkg::regAddrT rdAddrB,
	input  mipsPkg::regAddrT wrAddr,
	input  mipsPkg::dataT    wrData,
	output mipsPkg::dataT    rdDataA,
	output mipsPkg::dataT    rdDataB
);

	mipsPkg::dataT regs [2**$bits(mipsPkg::regAddrT)];

	// Register 0 is never written, so it stays at its reset value of zero
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < $size(regs); i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous read ports
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

/* src/alu.sv */
module alu (
	input  mipsPkg::aluModeE aluMode,
	input  mipsPkg::opcodeT  opcode,
	input  mipsPkg::functT   funct,
	input  mipsPkg::dataT    a,
	input  mipsPkg::dataT    b,
	output mipsPkg::dataT    result
);

	mipsPkg::aluOpE aluOp;
	logic [4:0] shamt;

	assign shamt = a[4:0];  // Variable shifts take the amount from rs

	// Operation select
	always_comb begin
		aluOp = mipsPkg::Add;
		case (aluMode)
			mipsPkg::AluFunct: begin
				case (funct)
					mipsPkg::FnAdd, mipsPkg::FnAddu: aluOp = mipsPkg::Add;
					mipsPkg::FnSub, mipsPkg::FnSubu: aluOp = mipsPkg::Sub;
					mipsPkg::FnAnd:  aluOp = mipsPkg::And;
					mipsPkg::FnOr:   aluOp = mipsPkg::Or;
					mipsPkg::FnNor:  aluOp = mipsPkg::Nor;
					mipsPkg::FnXor:  aluOp = mipsPkg::Xor;
					mipsPkg::FnSlt:  aluOp = mipsPkg::Slt;
					mipsPkg::FnSltu: aluOp = mipsPkg::Sltu;
					mipsPkg::FnSllv: aluOp = mipsPkg::Sllv;
					mipsPkg::FnSrlv: aluOp = mipsPkg::Srlv;
					mipsPkg::FnSrav: aluOp = mipsPkg::Srav;
					default: aluOp = mipsPkg::Add;
				endcase
			end
			mipsPkg::AluImm: begin
				case (opcode)
					mipsPkg::OpAddi, mipsPkg::OpAddiu: aluOp = mipsPkg::Add;
					mipsPkg::OpSlti:  aluOp = mipsPkg::Slt;
					mipsPkg::OpSltiu: aluOp = mipsPkg::Sltu;  // Sign-extended imm, unsigned compare
					mipsPkg::OpAndi:  aluOp = mipsPkg::And;
					mipsPkg::OpOri:   aluOp = mipsPkg::Or;
					mipsPkg::OpXori:  aluOp = mipsPkg::Xor;
					mipsPkg::OpLui:   aluOp = mipsPkg::Lui;
					default: aluOp = mipsPkg::Add;
				endcase
			end
			default: aluOp = mipsPkg::Add;  // Address arithmetic
		endcase
	end

	always_comb begin
		case (aluOp)
			mipsPkg::Add:  result = a + b;
			mipsPkg::Sub:  result = a - b;
			mipsPkg::And:  result = a & b;
			mipsPkg::Or:   result = a | b;
			mipsPkg::Nor:  result = ~(a | b);
			mipsPkg::Xor:  result = a ^ b;
			mipsPkg::Slt:  result = {31'b0, $signed(a) < $signed(b)};
			mipsPkg::Sltu: result = {31'b0, a < b};
			mipsPkg::Sllv: result = b << shamt;
			mipsPkg::Srlv: result = b >> shamt;
			mipsPkg::Srav: result = $signed(b) >>> shamt;  // Fills with the sign bit
			mipsPkg::Lui:  result = {b[15:0], 16'b0};
			default: result = a + b;
		endcase
	end

endmodule

/* src/controlUnit.sv */
module controlUnit (
	input  logic              CLK,
	input  logic              reset,
	input  logic              memReady,
	input  mipsPkg::opcodeT   opcode,
	output logic              irLoad,
	output logic              pcLoad,
	output logic              marLoad,
	output logic              mdrLoad,
	output logic              abLoad,
	output logic              regWrite,
	output logic              memValid,
	output logic              memWrite,
	output logic              addrFromMar,
	output logic              useImm,
	output logic              dstRt,
	output logic              wbFromMem,
	output mipsPkg::aluModeE  aluMode,
	output logic              resultValid
);

	mipsPkg::stateE state;
	mipsPkg::stateE nextState;
	logic xferDone;

	assign xferDone = memValid && memReady;  // Bus handshake this edge

	// Bus request flags follow the state they lead into, so they stay low through reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= mipsPkg::Fetch;
			memValid <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			state <= nextState;
			memValid <= nextState inside {mipsPkg::Fetch, mipsPkg::FetchWait,
				mipsPkg::MemRead, mipsPkg::MemWrite};
			memWrite <= nextState == mipsPkg::MemWrite;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			mipsPkg::Fetch, mipsPkg::FetchWait:
				nextState = xferDone ? mipsPkg::Decode : mipsPkg::FetchWait;
			mipsPkg::Decode: begin
				case (opcode)
					mipsPkg::OpRType: nextState = mipsPkg::ExecR;
					mipsPkg::OpAddi, mipsPkg::OpAddiu, mipsPkg::OpSlti, mipsPkg::OpSltiu,
					mipsPkg::OpAndi, mipsPkg::OpOri, mipsPkg::OpXori, mipsPkg::OpLui:
						nextState = mipsPkg::ExecI;
					mipsPkg::OpLw, mipsPkg::OpSw: nextState = mipsPkg::MemAddr;
					default: nextState = mipsPkg::Fetch;  // Unknown opcode retires as a no-op
				endcase
			end
			mipsPkg::ExecR, mipsPkg::ExecI: nextState = mipsPkg::WriteBack;
			mipsPkg::MemAddr:
				nextState = (opcode == mipsPkg::OpLw) ? mipsPkg::MemRead : mipsPkg::MemWrite;
			mipsPkg::MemRead: begin
				if (xferDone) begin
					nextState = mipsPkg::WriteBack;
				end
			end
			mipsPkg::MemWrite: begin
				if (xferDone) begin
					nextState = mipsPkg::Fetch;  // Store retires on the accepted write
				end
			end
			mipsPkg::WriteBack: nextState = mipsPkg::Fetch;
			default: nextState = mipsPkg::Fetch;
		endcase
	end

	// Per-state control outputs
	always_comb begin
		irLoad = 1'b0;
		pcLoad = 1'b0;
		marLoad = 1'b0;
		mdrLoad = 1'b0;
		abLoad = 1'b0;
		regWrite = 1'b0;
		addrFromMar = 1'b0;
		useImm = 1'b0;
		dstRt = 1'b0;
		wbFromMem = 1'b0;
		resultValid = 1'b0;
		aluMode = mipsPkg::AluAdd;
		case (state)
			mipsPkg::Fetch, mipsPkg::FetchWait: begin
				irLoad = xferDone;
				pcLoad = xferDone;
			end
			mipsPkg::Decode: abLoad = 1'b1;
			mipsPkg::ExecR: aluMode = mipsPkg::AluFunct;
			mipsPkg::ExecI: begin
				aluMode = mipsPkg::AluImm;
				useImm = 1'b1;
			end
			mipsPkg::MemAddr: begin
				useImm = 1'b1;  // Base plus offset
				marLoad = 1'b1;
			end
			mipsPkg::MemRead: begin
				addrFromMar = 1'b1;
				mdrLoad = xferDone;
			end
			mipsPkg::MemWrite: addrFromMar = 1'b1;
			mipsPkg::WriteBack: begin
				regWrite = 1'b1;
				resultValid = 1'b1;
				dstRt = opcode != mipsPkg::OpRType;  // rt for immediates and LW
				wbFromMem = opcode == mipsPkg::OpLw;
			end
			default: ;
		endcase
	end

endmodule

/* src/datapath.sv */
module datapath (
	input  logic              CLK,
	input  logic              reset,
	input  logic              irLoad,
	input  logic              pcLoad,
	input  logic              marLoad,
	input  logic              mdrLoad,
	input  logic              abLoad,
	input  logic              regWrite,
	input  logic              memValid,
	input  logic              memWrite,
	input  logic              addrFromMar,
	input  logic              useImm,
	input  logic              dstRt,
	input  logic              wbFromMem,
	input  mipsPkg::aluModeE  aluMode,
	input  mipsPkg::dataT     memRData,
	output mipsPkg::opcodeT   opcode,
	output mipsPkg::memAddrT  memAddr,
	output mipsPkg::dataT     memWData,
	output mipsPkg::regAddrT  resultReg,
	output mipsPkg::dataT     resultData
);

	mipsPkg::memAddrT pc;
	mipsPkg::memAddrT mar;
	mipsPkg::dataT ir;
	mipsPkg::dataT mdr;
	mipsPkg::dataT aReg;
	mipsPkg::dataT bReg;
	mipsPkg::dataT aluOut;
	mipsPkg::dataT rdDataA;
	mipsPkg::dataT rdDataB;
	mipsPkg::dataT immExt;
	mipsPkg::dataT aluB;
	mipsPkg::dataT aluResult;
	mipsPkg::regAddrT rs;
	mipsPkg::regAddrT rt;
	mipsPkg::regAddrT rd;
	mipsPkg::functT funct;
	logic zeroExt;

	// Instruction fields
	assign opcode = ir[31:26];
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign funct = ir[5:0];

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= mipsPkg::ResetPc;
		end else if (pcLoad) begin
			pc <= pc + mipsPkg::PcStep;
		end
	end

	always_ff @(posedge CLK) begin
		if (irLoad) begin
			ir <= memRData;
		end
		if (marLoad) begin
			mar <= {aluResult[8:2], 2'b00};  // Word aligned
		end
		if (mdrLoad) begin
			mdr <= memRData;
		end
		if (abLoad) begin
			aReg <= rdDataA;
			bReg <= rdDataB;
		end
		aluOut <= aluResult;  // Holds the execute result for writeback
	end

	// Logic immediates are zero-extended, the rest sign-extended
	assign zeroExt = opcode inside {mipsPkg::OpAndi, mipsPkg::OpOri, mipsPkg::OpXori};
	assign immExt = zeroExt ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
	assign aluB = useImm ? immExt : bReg;

	assign resultReg = dstRt ? rt : rd;
	assign resultData = wbFromMem ? mdr : aluOut;

	// Bus reads as zero while no request is open
	always_comb begin
		memAddr = '0;
		memWData = '0;
		if (memValid) begin
			memAddr = addrFromMar ? mar : pc;
			if (memWrite) begin
				memWData = bReg;  // Store data is rt
			end
		end
	end

	registerFile u_regFile (
		.CLK(CLK),
		.reset(reset),
		.regWrite(regWrite),
		.rdAddrA(rs),
		.rdAddrB(rt),
		.wrAddr(resultReg),
		.wrData(resultData),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	alu u_alu (
		.aluMode(aluMode),
		.opcode(opcode),
		.funct(funct),
		.a(aReg),
		.b(aluB),
		.result(aluResult)
	);

endmodule

/* src/mipsProcessor.sv */
module mipsProcessor (
	input  logic             CLK,
	input  logic             reset,
	input  logic             memReady,
	input  mipsPkg::dataT    memRData,
	output logic             memValid,
	output logic             memWrite,
	output mipsPkg::memAddrT memAddr,
	output mipsPkg::dataT    memWData,
	output logic             resultValid,
	output mipsPkg::regAddrT resultReg,
	output mipsPkg::dataT    resultData
);

	logic irLoad;
	logic pcLoad;
	logic marLoad;
	logic mdrLoad;
	logic abLoad;
	logic regWrite;
	logic addrFromMar;
	logic useImm;
	logic dstRt;
	logic wbFromMem;
	mipsPkg::aluModeE aluMode;
	mipsPkg::opcodeT opcode;

	controlUnit u_ctrl (
		.CLK(CLK), .reset(reset), .memReady(memReady), .opcode(opcode),
		.irLoad(irLoad), .pcLoad(pcLoad), .marLoad(marLoad), .mdrLoad(mdrLoad),
		.abLoad(abLoad), .regWrite(regWrite), .memValid(memValid), .memWrite(memWrite),
		.addrFromMar(addrFromMar), .useImm(useImm), .dstRt(dstRt), .wbFromMem(wbFromMem),
		.aluMode(aluMode), .resultValid(resultValid)
	);

	datapath u_dp (
		.CLK(CLK), .reset(reset), .irLoad(irLoad), .pcLoad(pcLoad), .marLoad(marLoad),
		.mdrLoad(mdrLoad), .abLoad(abLoad), .regWrite(regWrite), .memValid(memValid),
		.memWrite(memWrite), .addrFromMar(addrFromMar), .useImm(useImm), .dstRt(dstRt),
		.wbFromMem(wbFromMem), .aluMode(aluMode), .memRData(memRData), .opcode(opcode),
		.memAddr(memAddr), .memWData(memWData), .resultReg(resultReg), .resultData(resultData)
	);

endmodule

/* include/mipsTests.svh */
`ifndef MIPS_TESTS_SVH
`define MIPS_TESTS_SVH

// Fetch addresses start at zero and step by one word
task automatic testReset();
	mipsPkg::dataT prog[$];
	prog = {
		iType(mipsPkg::OpAddi, 5'd1, 5'd0, 16'd1),
		iType(mipsPkg::OpAddi, 5'd2, 5'd1, 16'd2),
		iType(mipsPkg::OpAddi, 5'd3, 5'd0, 16'hfffd),
		iType(mipsPkg::OpAddi, 5'd4, 5'd3, 16'd4)
	};
	runProgram("reset", prog);
	for (int i = 0; i < prog.size(); i++) begin
		checkAddr("reset", mipsPkg::memAddrT'(4 * i), readLog[i]);
	end
	reportTest("reset");
endtask

task automatic testRType();
	mipsPkg::dataT prog[$];
	prog = {
		iType(mipsPkg::OpAddi, 5'd1, 5'd0, 16'hfff9),  // -7
		iType(mipsPkg::OpAddi, 5'd2, 5'd0, 16'd5),
		iType(mipsPkg::OpAddi, 5'd3, 5'd0, 16'h7fff),
		rType(mipsPkg::FnAdd, 5'd4, 5'd1, 5'd2),
		rType(mipsPkg::FnAddu, 5'd5, 5'd3, 5'd3),
		rType(mipsPkg::FnSub, 5'd6, 5'd2, 5'd1),
		rType(mipsPkg::FnSubu, 5'd7, 5'd1, 5'd3),
		rType(mipsPkg::FnAnd, 5'd8, 5'd1, 5'd3),
		rType(mipsPkg::FnOr, 5'd9, 5'd1, 5'd2),
		rType(mipsPkg::FnNor, 5'd10, 5'd1, 5'd2),
		rType(mipsPkg::FnXor, 5'd11, 5'd1, 5'd3),
		rType(mipsPkg::FnSlt, 5'd12, 5'd1, 5'd2),   // Negative is less when signed
		rType(mipsPkg::FnSltu, 5'd13, 5'd1, 5'd2),  // but greater when unsigned
		rType(mipsPkg::FnSlt, 5'd14, 5'd2, 5'd1),
		rType(mipsPkg::FnSltu, 5'd15, 5'd2, 5'd1)
	};
	runProgram("rtype", prog);
	reportTest("rtype");
endtask

// Immediates past the setup ADDI have bit 15 set
task automatic testImmediate();
	mipsPkg::dataT prog[$];
	prog = {
		iType(mipsPkg::OpAddi, 5'd1, 5'd0, 16'h1234),
		iType(mipsPkg::OpAddiu, 5'd2, 5'd1, 16'h8000),
		iType(mipsPkg::OpSlti, 5'd3, 5'd1, 16'h8000),
		iType(mipsPkg::OpSlti, 5'd4, 5'd2, 16'hffff),
		iType(mipsPkg::OpOri, 5'd7, 5'd1, 16'h8000),
		iType(mipsPkg::OpSltiu, 5'd5, 5'd7, 16'h8000),  // Compares against 0xffff8000
		iType(mipsPkg::OpAndi, 5'd6, 5'd2, 16'h8f0f),
		iType(mipsPkg::OpXori, 5'd8, 5'd2, 16'hf00f),
		iType(mipsPkg::OpLui, 5'd9, 5'd0, 16'h8765)
	};
	runProgram("immediate", prog);
	checkData("immediate", 32'h0000_8204, gotData[6]);  // Upper half stays clear
	reportTest("immediate");
endtask

task automatic testShift();
	mipsPkg::dataT prog[$];
	prog = {
		iType(mipsPkg::OpAddi, 5'd1, 5'd0, 16'hedcb),
		iType(mipsPkg::OpAddi, 5'd2, 5'd0, 16'd4),
		iType(mipsPkg::OpAddi, 5'd3, 5'd0, 16'd31),
		iType(mipsPkg::OpAddi, 5'd4, 5'd0, 16'd33),  // Amount 1 after masking
		rType(mipsPkg::FnSllv, 5'd5, 5'd2, 5'd1),
		rType(mipsPkg::FnSrlv, 5'd6, 5'd2, 5'd1),
		rType(mipsPkg::FnSrav, 5'd7, 5'd2, 5'd1),
		rType(mipsPkg::FnSrav, 5'd8, 5'd3, 5'd1),
		rType(mipsPkg::FnSrav, 5'd9, 5'd4, 5'd1),
		rType(mipsPkg::FnSrlv, 5'd10, 5'd3, 5'd1),
		rType(mipsPkg::FnSllv, 5'd11, 5'd0, 5'd1)
	};
	runProgram("shift", prog);
	checkData("shift", 32'hffff_fedc, gotData[6]);
	checkData("shift", 32'hffff_ffff, gotData[7]);
	reportTest("shift");
endtask

task automatic testMemory();
	mipsPkg::dataT prog[$];
	prog = {
		iType(mipsPkg::OpAddi, 5'd1, 5'd0, 16'h0100),
		iType(mipsPkg::OpLui, 5'd2, 5'd0, 16'hcafe),
		iType(mipsPkg::OpOri, 5'd2, 5'd2, 16'hf00d),
		iType(mipsPkg::OpSw, 5'd2, 5'd1, 16'd8),
		iType(mipsPkg::OpAddi, 5'd3, 5'd0, 16'hffff),
		iType(mipsPkg::OpSw, 5'd3, 5'd1, 16'hfffc),  // Negative offset
		iType(mipsPkg::OpLw, 5'd4, 5'd1, 16'd8),
		iType(mipsPkg::OpLw, 5'd5, 5'd1, 16'hfffc),
		iType(mipsPkg::OpLw, 5'd6, 5'd1, 16'h0012)   // Low bits dropped, reads fill
	};
	runProgram("memory", prog);
	checkAddr("memory", 9'h108, gotStoreAddr[0]);
	checkData("memory", 32'hcafe_f00d, gotData[4]);
	reportTest("memory");
endtask

// Register 0 pulses the result port but keeps reading zero
task automatic testRegZero();
	mipsPkg::dataT prog[$];
	prog = {
		iType(mipsPkg::OpAddi, 5'd0, 5'd0, 16'h0055),
		rType(mipsPkg::FnAdd, 5'd1, 5'd0, 5'd0),
		iType(mipsPkg::OpOri, 5'd0, 5'd0, 16'hffff),
		iType(mipsPkg::OpAddi, 5'd2, 5'd0, 16'd7),
		iType(mipsPkg::OpLui, 5'd0, 5'd0, 16'h1234),
		rType(mipsPkg::FnSub, 5'd3, 5'd2, 5'd0)
	};
	runProgram("regzero", prog);
	checkReg("regzero", 5'd0, gotReg[0]);
	checkData("regzero", 32'h0000_0055, gotData[0]);
	checkData("regzero", 32'h0000_0000, gotData[1]);
	checkData("regzero", 32'h0000_0007, gotData[5]);
	reportTest("regzero");
endtask

`endif

/* verification/tbMips.sv */
module tbMips;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MaxWait = 3;
	localparam int ResetCycles = 3;
	localparam int NumTests = 6;
	localparam int NumInstr = 54;  // All test programs together
	localparam int MemWords = 128;

	logic CLK = 1'b0;
	logic reset;
	logic memReady = 1'b0;
	mipsPkg::dataT memRData = '0;
	logic memValid;
	logic memWrite;
	mipsPkg::memAddrT memAddr;
	mipsPkg::dataT memWData;
	logic resultValid;
	mipsPkg::regAddrT resultReg;
	mipsPkg::dataT resultData;

	mipsPkg::dataT ram [MemWords];
	mipsPkg::dataT image [MemWords];  // Copied into the RAM during reset
	mipsPkg::dataT modelMem [MemWords];
	mipsPkg::dataT modelRegs [32];
	int waitLeft = 0;
	int errorCount;
	int testCount;
	int failedTests;
	int testErrorsAtStart;

	// Seen on the DUT ports
	mipsPkg::regAddrT gotReg[$];
	mipsPkg::dataT gotData[$];
	mipsPkg::memAddrT gotStoreAddr[$];
	mipsPkg::dataT gotStoreData[$];
	mipsPkg::memAddrT readLog[$];
	// Predicted by the reference model
	mipsPkg::regAddrT expReg[$];
	mipsPkg::dataT expData[$];
	mipsPkg::memAddrT expStoreAddr[$];
	mipsPkg::dataT expStoreData[$];

	mipsProcessor u_dut (
		.CLK(CLK),
		.reset(reset),
		.memReady(memReady),
		.memRData(memRData),
		.memValid(memValid),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWData(memWData),
		.resultValid(resultValid),
		.resultReg(resultReg),
		.resultData(resultData)
	);

	always #10 CLK = ~CLK;

	// RAM answers each request after 0 to MaxWait idle cycles
	always @(negedge CLK) begin
		if (!memValid || memReady) begin
			memReady = 1'b0;
			memRData = '0;
			waitLeft = $urandom_range(MaxWait, 0);
		end else if (waitLeft > 0) begin
			waitLeft--;
		end else begin
			memReady = 1'b1;
			memRData = memWrite ? '0 : ram[memAddr[8:2]];
		end
	end

	// Bus transfers and register writes complete on the rising edge
	always @(posedge CLK) begin
		if (reset) begin
			foreach (ram[i]) begin
				ram[i] = image[i];
			end
			gotReg.delete();
			gotData.delete();
			gotStoreAddr.delete();
			gotStoreData.delete();
			readLog.delete();
		end else begin
			if (resultValid) begin
				gotReg.push_back(resultReg);
				gotData.push_back(resultData);
			end
			if (memValid && memReady) begin
				if (memWrite) begin
					ram[memAddr[8:2]] = memWData;
					gotStoreAddr.push_back(memAddr);
					gotStoreData.push_back(memWData);
				end else begin
					readLog.push_back(memAddr);
				end
			end
		end
	end

	initial begin
		repeat (NumInstr * (4 + MaxWait) * 2 + NumTests * (ResetCycles + 2)) @(posedge CLK);
		$display("Timeout: the DUT stopped retiring instructions and the run was stopped");
		$display("*** FAILED ***");
		$finish;
	end

	task automatic checkData(string name, mipsPkg::dataT expected, mipsPkg::dataT actual);
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkReg(string name, mipsPkg::regAddrT expected, mipsPkg::regAddrT actual);
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s: expected r%0d, actual r%0d", name, expected, actual);
		end
	endtask

	task automatic checkAddr(string name, mipsPkg::memAddrT expected, mipsPkg::memAddrT actual);
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic mipsPkg::dataT rType(mipsPkg::functT fn, mipsPkg::regAddrT rd,
		mipsPkg::regAddrT rs, mipsPkg::regAddrT rt);
		return {mipsPkg::OpRType, rs, rt, rd, 5'b0, fn};
	endfunction

	function automatic mipsPkg::dataT iType(mipsPkg::opcodeT op, mipsPkg::regAddrT rt,
		mipsPkg::regAddrT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Unsupported opcode, so stray fetches run as no-ops
	function automatic mipsPkg::dataT fillWord(int idx);
		return {6'h3f, 19'b0, 7'(idx)};
	endfunction

	// Reference model, one instruction per call
	task automatic modelExec(mipsPkg::dataT instr);
		mipsPkg::dataT a;
		mipsPkg::dataT b;
		mipsPkg::dataT simm;
		mipsPkg::dataT zimm;
		mipsPkg::dataT value;
		mipsPkg::regAddrT dest;
		mipsPkg::memAddrT addr;
		logic writes;
		a = modelRegs[instr[25:21]];
		b = modelRegs[instr[20:16]];
		simm = {{16{instr[15]}}, instr[15:0]};
		zimm = {16'b0, instr[15:0]};
		addr = mipsPkg::memAddrT'(a + simm) & 9'h1fc;  // Word address only
		dest = instr[20:16];
		writes = 1'b1;
		value = '0;
		case (instr[31:26])
			mipsPkg::OpRType: begin
				dest = instr[15:11];
				case (instr[5:0])
					mipsPkg::FnAdd, mipsPkg::FnAddu: value = a + b;
					mipsPkg::FnSub, mipsPkg::FnSubu: value = a - b;
					mipsPkg::FnAnd: value = a & b;
					mipsPkg::FnOr: value = a | b;
					mipsPkg::FnNor: value = ~(a | b);
					mipsPkg::FnXor: value = a ^ b;
					mipsPkg::FnSlt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mipsPkg::FnSltu: value = (a < b) ? 32'd1 : 32'd0;
					mipsPkg::FnSllv: value = b << a[4:0];
					mipsPkg::FnSrlv: value = b >> a[4:0];
					mipsPkg::FnSrav: value = $signed(b) >>> a[4:0];
					default: writes = 1'b0;
				endcase
			end
			mipsPkg::OpAddi, mipsPkg::OpAddiu: value = a + simm;
			mipsPkg::OpSlti: value = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			mipsPkg::OpSltiu: value = (a < simm) ? 32'd1 : 32'd0;
			mipsPkg::OpAndi: value = a & zimm;
			mipsPkg::OpOri: value = a | zimm;
			mipsPkg::OpXori: value = a ^ zimm;
			mipsPkg::OpLui: value = {instr[15:0], 16'b0};
			mipsPkg::OpLw: value = modelMem[addr[8:2]];
			mipsPkg::OpSw: begin
				writes = 1'b0;
				modelMem[addr[8:2]] = b;
				expStoreAddr.push_back(addr);
				expStoreData.push_back(b);
			end
			default: writes = 1'b0;
		endcase
		if (writes) begin
			if (dest != '0) begin
				modelRegs[dest] = value;
			end
			expReg.push_back(dest);
			expData.push_back(value);
		end
	endtask

	task automatic applyReset(string name);
		@(negedge CLK);
		reset = 1'b1;
		repeat (ResetCycles) begin
			@(negedge CLK);
			if (memValid !== 1'b0 || resultValid !== 1'b0) begin
				errorCount++;
				$display("%s: memValid or resultValid is high during reset", name);
			end
		end
		reset = 1'b0;
		@(negedge CLK);
		if (memValid !== 1'b1) begin
			errorCount++;
			$display("%s: memValid did not rise in the cycle after reset", name);
		end
	endtask

	// Loads a program, runs it from reset and compares every retired result and store
	task automatic runProgram(string name, mipsPkg::dataT prog[$]);
		testErrorsAtStart = errorCount;
		foreach (image[i]) begin
			image[i] = (i < prog.size()) ? prog[i] : fillWord(i);
			modelMem[i] = image[i];
		end
		foreach (modelRegs[i]) begin
			modelRegs[i] = '0;
		end
		expReg.delete();
		expData.delete();
		expStoreAddr.delete();
		expStoreData.delete();
		foreach (prog[i]) begin
			modelExec(prog[i]);
		end
		applyReset(name);
		while (gotReg.size() < expReg.size() || gotStoreAddr.size() < expStoreAddr.size()) begin
			@(negedge CLK);
		end
		foreach (expReg[i]) begin
			checkReg(name, expReg[i], gotReg[i]);
			checkData(name, expData[i], gotData[i]);
		end
		foreach (expStoreAddr[i]) begin
			checkAddr(name, expStoreAddr[i], gotStoreAddr[i]);
			checkData(name, expStoreData[i], gotStoreData[i]);
		end
	endtask

	task automatic reportTest(string name);
		testCount++;
		if (errorCount == testErrorsAtStart) begin
			$display("test %s: ok", name);
		end else begin
			failedTests++;
			$display("test %s: %0d errors", name, errorCount - testErrorsAtStart);
		end
	endtask

	`include "mipsTests.svh"

	initial begin
		void'($urandom(32'hbdb4dc7f));
		reset = 1'b1;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		testErrorsAtStart = 0;
		testReset();
		testRType();
		testImmediate();
		testShift();
		testMemory();
		testRegZero();
		$display("Tests run: %0d, failed: %0d, check errors: %0d",
			testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
src/mipsPkg.sv
src/registerFile.sv
src/alu.sv
src/controlUnit.sv
src/datapath.sv
src/mipsProcessor.sv
verification/tbMips.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tbMips
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG)
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
